//--- src/core_pkg.sv
// Core package with sequencer and fetcher states, lane data and data memory store types
package core_pkg;

    localparam int DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] data_t;

    // One instruction at a time walks through these states
    typedef enum logic [2:0] {
        IDLE    = 3'b000,
        FETCH   = 3'b001,
        DECODE  = 3'b010,
        EXECUTE = 3'b011,
        WAIT    = 3'b100,
        UPDATE  = 3'b101,
        DONE    = 3'b111
    } core_state_t;

    // Program memory request progress
    typedef enum logic [2:0] {
        FETCHER_IDLE = 3'b000,
        FETCHING     = 3'b001,
        FETCHED      = 3'b010
    } fetcher_state_t;

    // Condition flags from the last CMP
    typedef struct packed {
        logic negative;
        logic zero;
        logic positive;
    } nzp_t;

    // A single store on the data write port
    typedef struct packed {
        data_t address;
        data_t data;
    } mem_write_t;

endpackage

//--- src/isa_pkg.sv
// ISA package with opcodes, the instruction layout and decoded control fields
package isa_pkg;

    localparam int INSTR_BITS = 16;
    localparam int PC_BITS    = 8;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        BRNZP = 4'd1,
        CMP   = 4'd2,
        ADD   = 4'd3,
        SUB   = 4'd4,
        MUL   = 4'd5,
        STR   = 4'd8,
        CONST = 4'd9,
        RET   = 4'd15
    } opcode_t;

    // Branch condition sits in rd[3:1], the immediate is {rs, rt}
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL,
        ALU_CONST
    } alu_select_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs;
        logic [3:0]  rt;
        logic [7:0]  imm;
        logic [2:0]  nzp_mask;
        logic        reg_write_enable;
        alu_select_t alu_select;
        logic        nzp_write_enable;
        logic        store_enable;
        logic        branch;
        logic        ret;
    } decoded_t;

endpackage

//--- src/fetcher.sv
// Instruction fetcher that reads the word at the current PC over the program memory handshake
`timescale 1ns/1ps

module fetcher #(
    parameter int PROGRAM_MEM_ADDR_BITS = 8,
    parameter int PROGRAM_MEM_DATA_BITS = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  core_pkg::core_state_t            core_state,
    input  logic [isa_pkg::PC_BITS-1:0]      current_pc,
    output logic                             program_read_valid,
    output logic [PROGRAM_MEM_ADDR_BITS-1:0] program_read_address,
    input  logic                             program_read_ready,
    input  logic [PROGRAM_MEM_DATA_BITS-1:0] program_read_data,
    output core_pkg::fetcher_state_t         fetcher_state,
    output logic [PROGRAM_MEM_DATA_BITS-1:0] instruction
);
    import core_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetcher_state        <= FETCHER_IDLE;
            program_read_valid   <= 1'b0;
            program_read_address <= '0;
        end else begin
            case (fetcher_state)
                FETCHER_IDLE: begin
                    if (core_state == FETCH) begin
                        fetcher_state        <= FETCHING;
                        program_read_valid   <= 1'b1;
                        program_read_address <= PROGRAM_MEM_ADDR_BITS'(current_pc);
                    end
                end
                FETCHING: begin
                    // Address stays put until memory takes the request
                    if (program_read_ready) begin
                        fetcher_state      <= FETCHED;
                        program_read_valid <= 1'b0;
                    end
                end
                FETCHED: begin
                    if (core_state == DECODE) begin
                        fetcher_state <= FETCHER_IDLE;
                    end
                end
                default: fetcher_state <= FETCHER_IDLE;
            endcase
        end
    end

    // Capture the word on the accepted transfer
    always_ff @(posedge clk) begin
        if (fetcher_state == FETCHING && program_read_ready) begin
            instruction <= program_read_data;
        end
    end
endmodule

//--- src/decoder.sv
// Instruction decoder that registers the control fields of the fetched word
`timescale 1ns/1ps

module decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    input  isa_pkg::instr_t       instruction,
    output isa_pkg::decoded_t     decoded
);
    import core_pkg::*;
    import isa_pkg::*;

    decoded_t next_decoded;

    always_comb begin
        next_decoded          = '0;
        next_decoded.opcode   = instruction.opcode;
        next_decoded.rd       = instruction.rd;
        next_decoded.rs       = instruction.rs;
        next_decoded.rt       = instruction.rt;
        next_decoded.imm      = {instruction.rs, instruction.rt};
        next_decoded.nzp_mask = instruction.rd[3:1];
        case (instruction.opcode)
            ADD: begin
                next_decoded.reg_write_enable = 1'b1;
                next_decoded.alu_select       = ALU_ADD;
            end
            SUB: begin
                next_decoded.reg_write_enable = 1'b1;
                next_decoded.alu_select       = ALU_SUB;
            end
            MUL: begin
                next_decoded.reg_write_enable = 1'b1;
                next_decoded.alu_select       = ALU_MUL;
            end
            CONST: begin
                next_decoded.reg_write_enable = 1'b1;
                next_decoded.alu_select       = ALU_CONST;
            end
            CMP:     next_decoded.nzp_write_enable = 1'b1;
            BRNZP:   next_decoded.branch = 1'b1;
            STR:     next_decoded.store_enable = 1'b1;
            RET:     next_decoded.ret = 1'b1;
            // NOP and unused opcodes leave every enable clear
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (core_state == DECODE) begin
            decoded <= next_decoded;
        end
    end
endmodule

//--- src/alu.sv
// Lane ALU computing add, sub, mul and const results plus compare flags
`timescale 1ns/1ps

module alu (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    input  isa_pkg::decoded_t     decoded,
    input  core_pkg::data_t       rs_value,
    input  core_pkg::data_t       rt_value,
    output core_pkg::data_t       alu_out,
    output core_pkg::nzp_t        nzp
);
    import core_pkg::*;
    import isa_pkg::*;

    // One extra bit keeps the sign of any signed difference
    logic signed [DATA_BITS:0] difference;

    assign difference = $signed({rs_value[DATA_BITS-1], rs_value})
                      - $signed({rt_value[DATA_BITS-1], rt_value});

    always_ff @(posedge clk) begin
        if (core_state == EXECUTE) begin
            case (decoded.alu_select)
                ALU_ADD: alu_out <= rs_value + rt_value;
                ALU_SUB: alu_out <= rs_value - rt_value;
                ALU_MUL: alu_out <= rs_value * rt_value;
                default: alu_out <= decoded.imm;
            endcase
        end
    end

    // Flags commit with the rest of the instruction in UPDATE
    always_ff @(posedge clk) begin
        if (reset) begin
            nzp <= '0;
        end else if (core_state == UPDATE && decoded.nzp_write_enable) begin
            nzp.negative <= (difference < 0);
            nzp.zero     <= (difference == 0);
            nzp.positive <= (difference > 0);
        end
    end
endmodule

//--- src/reg_file.sv
// Lane register file with read-only zero, lane count and lane index registers
`timescale 1ns/1ps

module reg_file #(
    parameter int THREADS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    input  isa_pkg::decoded_t     decoded,
    input  logic [3:0]            lane_index,
    input  core_pkg::data_t       alu_out,
    output core_pkg::data_t       rs_value,
    output core_pkg::data_t       rt_value,
    output core_pkg::mem_write_t  lane_store
);
    import core_pkg::*;

    localparam int WRITABLE = 13;

    data_t registers [WRITABLE];

    // r13 is zero, r14 the lane count, r15 this lane's index
    function automatic data_t read_reg(input logic [3:0] index);
        case (index)
            4'd13:   read_reg = '0;
            4'd14:   read_reg = DATA_BITS'(THREADS);
            4'd15:   read_reg = data_t'(lane_index);
            default: read_reg = registers[index];
        endcase
    endfunction

    always_comb begin
        rs_value = read_reg(decoded.rs);
        rt_value = read_reg(decoded.rt);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WRITABLE; i++) begin
                registers[i] <= '0;
            end
        end else if (core_state == UPDATE && decoded.reg_write_enable
                     && decoded.rd < 4'(WRITABLE)) begin
            registers[decoded.rd] <= alu_out;
        end
    end

    // STR writes rt to the address held in rs
    assign lane_store.address = rs_value;
    assign lane_store.data    = rt_value;
endmodule

//--- src/store_unit.sv
// Store unit that sends one store per lane, in lane order, over the data write port
`timescale 1ns/1ps

module store_unit #(
    parameter int THREADS = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  core_pkg::core_state_t              core_state,
    input  isa_pkg::decoded_t                  decoded,
    input  core_pkg::mem_write_t [THREADS-1:0] lane_stores,
    output logic                               data_write_valid,
    output core_pkg::mem_write_t               data_write,
    input  logic                               data_write_ready,
    output logic                               store_done
);
    import core_pkg::*;

    localparam int LANE_BITS = (THREADS > 1) ? $clog2(THREADS) : 1;

    logic [LANE_BITS-1:0] lane;
    logic                 last_lane;

    assign last_lane = (lane == LANE_BITS'(THREADS - 1));

    // Lane values hold still until UPDATE, so the payload is stable under back-pressure
    assign data_write = lane_stores[lane];

    always_ff @(posedge clk) begin
        if (reset) begin
            data_write_valid <= 1'b0;
            store_done       <= 1'b0;
            lane             <= '0;
        end else begin
            store_done <= 1'b0;
            if (!data_write_valid) begin
                // Valid rises as the core steps from EXECUTE into WAIT
                if (core_state == EXECUTE && decoded.store_enable) begin
                    data_write_valid <= 1'b1;
                    lane             <= '0;
                end
            end else if (data_write_ready) begin
                if (last_lane) begin
                    data_write_valid <= 1'b0;
                    store_done       <= 1'b1;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end
endmodule

//--- src/core_scheduler.sv
// Core scheduler that steps the instruction states, holds the PC and resolves branches
`timescale 1ns/1ps

module core_scheduler (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  core_pkg::fetcher_state_t    fetcher_state,
    input  isa_pkg::decoded_t           decoded,
    input  core_pkg::nzp_t              lane0_nzp,
    input  logic                        store_done,
    output core_pkg::core_state_t       core_state,
    output logic [isa_pkg::PC_BITS-1:0] current_pc,
    output logic                        done
);
    import core_pkg::*;

    logic branch_taken;

    // Every lane follows lane 0 since lanes never diverge
    assign branch_taken = decoded.branch && |(decoded.nzp_mask & lane0_nzp);

    assign done = (core_state == DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state <= IDLE;
            current_pc <= '0;
        end else begin
            case (core_state)
                IDLE, DONE: begin
                    if (start) begin
                        current_pc <= '0;
                        core_state <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetcher_state == FETCHED) begin
                        core_state <= DECODE;
                    end
                end
                DECODE: begin
                    core_state <= EXECUTE;
                end
                EXECUTE: begin
                    if (decoded.store_enable) begin
                        core_state <= WAIT;
                    end else begin
                        core_state <= UPDATE;
                    end
                end
                WAIT: begin
                    if (store_done) begin
                        core_state <= UPDATE;
                    end
                end
                UPDATE: begin
                    if (decoded.ret) begin
                        core_state <= DONE;
                    end else begin
                        current_pc <= branch_taken ? decoded.imm : current_pc + 1'b1;
                        core_state <= FETCH;
                    end
                end
                default: core_state <= IDLE;
            endcase
        end
    end
endmodule

//--- src/simt_core.sv
// SIMT core top level with fetcher, decoder, scheduler, lane ALUs and register files
`timescale 1ns/1ps

module simt_core #(
    parameter int THREADS               = 4,
    parameter int PROGRAM_MEM_ADDR_BITS = 8,
    parameter int PROGRAM_MEM_DATA_BITS = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    output logic                             done,
    output logic                             program_read_valid,
    output logic [PROGRAM_MEM_ADDR_BITS-1:0] program_read_address,
    input  logic                             program_read_ready,
    input  logic [PROGRAM_MEM_DATA_BITS-1:0] program_read_data,
    output logic                             data_write_valid,
    output core_pkg::mem_write_t             data_write,
    input  logic                             data_write_ready
);
    import core_pkg::*;
    import isa_pkg::*;

    core_state_t                      core_state;
    fetcher_state_t                   fetcher_state;
    logic [PC_BITS-1:0]               current_pc;
    logic [PROGRAM_MEM_DATA_BITS-1:0] fetched_word;
    instr_t                           instruction;
    decoded_t                         decoded;
    nzp_t [THREADS-1:0]               lane_nzp;
    mem_write_t [THREADS-1:0]         lane_stores;
    logic                             store_done;

    // Decoder sees the instruction-width part of the program word
    assign instruction = fetched_word[INSTR_BITS-1:0];

    core_scheduler core_scheduler_inst (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .fetcher_state (fetcher_state),
        .decoded       (decoded),
        .lane0_nzp     (lane_nzp[0]),
        .store_done    (store_done),
        .core_state    (core_state),
        .current_pc    (current_pc),
        .done          (done)
    );

    fetcher #(
        .PROGRAM_MEM_ADDR_BITS (PROGRAM_MEM_ADDR_BITS),
        .PROGRAM_MEM_DATA_BITS (PROGRAM_MEM_DATA_BITS)
    ) fetcher_inst (
        .clk                  (clk),
        .reset                (reset),
        .core_state           (core_state),
        .current_pc           (current_pc),
        .program_read_valid   (program_read_valid),
        .program_read_address (program_read_address),
        .program_read_ready   (program_read_ready),
        .program_read_data    (program_read_data),
        .fetcher_state        (fetcher_state),
        .instruction          (fetched_word)
    );

    decoder decoder_inst (
        .clk         (clk),
        .reset       (reset),
        .core_state  (core_state),
        .instruction (instruction),
        .decoded     (decoded)
    );

    store_unit #(
        .THREADS (THREADS)
    ) store_unit_inst (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .decoded          (decoded),
        .lane_stores      (lane_stores),
        .data_write_valid (data_write_valid),
        .data_write       (data_write),
        .data_write_ready (data_write_ready),
        .store_done       (store_done)
    );

    for (genvar i = 0; i < THREADS; i++) begin : g_lane
        data_t rs_value;
        data_t rt_value;
        data_t alu_out;

        reg_file #(
            .THREADS (THREADS)
        ) reg_file_inst (
            .clk        (clk),
            .reset      (reset),
            .core_state (core_state),
            .decoded    (decoded),
            .lane_index (4'(i)),
            .alu_out    (alu_out),
            .rs_value   (rs_value),
            .rt_value   (rt_value),
            .lane_store (lane_stores[i])
        );

        alu alu_inst (
            .clk        (clk),
            .reset      (reset),
            .core_state (core_state),
            .decoded    (decoded),
            .rs_value   (rs_value),
            .rt_value   (rt_value),
            .alu_out    (alu_out),
            .nzp        (lane_nzp[i])
        );
    end
endmodule

//--- tb/simt_core_tb.sv
// Testbench for the SIMT core with program and data memory models and a table of test programs
`timescale 1ns/1ps

module simt_core_tb;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int THREADS         = 4;
    localparam int NUM_TESTS       = 3;
    localparam int MAX_WORDS       = 16;
    localparam int MAX_STORES      = 16;
    localparam int MAX_FETCHES     = 16;
    localparam int MAX_FETCH_DELAY = 3;
    localparam int MAX_WRITE_DELAY = 2;
    localparam int DELAY_SLOTS     = 64;
    localparam int LOOP_LIMIT      = 3;
    localparam int WATCHDOG_MARGIN = 400;

    logic       clk;
    logic       reset;
    logic       start;
    logic       done;
    logic       program_read_valid;
    logic [7:0] program_read_address;
    logic       program_read_ready = 1'b0;
    logic [15:0] program_read_data = '0;
    logic       data_write_valid;
    mem_write_t data_write;
    logic       data_write_ready = 1'b0;

    // Test table of program words, expected PC order and expected stores
    logic [15:0]        program_table [NUM_TESTS][MAX_WORDS];
    int                 program_length [NUM_TESTS];
    logic [PC_BITS-1:0] pc_table [NUM_TESTS][MAX_FETCHES];
    int                 fetch_count [NUM_TESTS];
    mem_write_t         store_table [NUM_TESTS][MAX_STORES];
    int                 store_count [NUM_TESTS];

    logic [15:0]        program_mem [256];
    int                 fetch_delay [DELAY_SLOTS];
    int                 write_delay [DELAY_SLOTS];
    int                 fetch_wait = 0;
    int                 write_wait = 0;
    int                 fetch_draw = 0;
    int                 write_draw = 0;

    int                 current_test = 0;
    int                 fetch_index = 0;
    int                 store_index = 0;
    int                 value_errors = 0;
    int                 other_errors = 0;
    int                 watchdog_cycles = 0;
    logic               read_pending = 1'b0;
    logic               write_pending = 1'b0;
    logic [7:0]         held_address;
    mem_write_t         held_write;

    simt_core #(
        .THREADS               (THREADS),
        .PROGRAM_MEM_ADDR_BITS (8),
        .PROGRAM_MEM_DATA_BITS (16)
    ) simt_core_inst (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .done                 (done),
        .program_read_valid   (program_read_valid),
        .program_read_address (program_read_address),
        .program_read_ready   (program_read_ready),
        .program_read_data    (program_read_data),
        .data_write_valid     (data_write_valid),
        .data_write           (data_write),
        .data_write_ready     (data_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_store(input string name, input mem_write_t actual,
                               input mem_write_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic check_pc(input string name, input logic [PC_BITS-1:0] actual,
                            input logic [PC_BITS-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic check_state(input core_state_t actual, input core_state_t expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED core_state: got 0x%h expected 0x%h", actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, actual, expected);
        end
    endtask

    function automatic mem_write_t make_store(input int address, input int data);
        mem_write_t store;
        store.address = data_t'(address);
        store.data    = data_t'(data);
        return store;
    endfunction

    task automatic load_tables();
        int n;
        // Arithmetic with r15 and r14, then three STR to 0x10 + lane
        program_table[0][0] = 16'h9060;
        program_table[0][1] = 16'h9410;
        program_table[0][2] = 16'h354F;
        program_table[0][3] = 16'h31FE;
        program_table[0][4] = 16'h52F0;
        program_table[0][5] = 16'h43F0;
        program_table[0][6] = 16'h8051;
        program_table[0][7] = 16'h8052;
        program_table[0][8] = 16'h8053;
        program_table[0][9] = 16'hF000;
        program_length[0] = 10;
        for (int i = 0; i < 10; i++) begin
            pc_table[0][i] = PC_BITS'(i);
        end
        fetch_count[0] = 10;
        for (int l = 0; l < THREADS; l++) begin
            store_table[0][l]             = make_store(16 + l, l + THREADS);
            store_table[0][THREADS + l]   = make_store(16 + l, l * 8'h60);
            store_table[0][2*THREADS + l] = make_store(16 + l, l - 8'h60);
        end
        store_count[0] = 3 * THREADS;

        // Count r1 up with CMP and BRNZP on the negative flag
        // Each lane's limit is LOOP_LIMIT plus its index, and only lane 0's flags steer the loop
        program_table[1][0] = 16'h9100;
        program_table[1][1] = 16'h9201;
        program_table[1][2] = {8'h93, 8'(LOOP_LIMIT)};
        program_table[1][3] = 16'h333F;
        program_table[1][4] = 16'h3112;
        program_table[1][5] = 16'h2013;
        program_table[1][6] = 16'h1804;
        program_table[1][7] = 16'h80F1;
        program_table[1][8] = 16'hF000;
        program_length[1] = 9;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            pc_table[1][n] = PC_BITS'(i);
            n++;
        end
        // Lane 0 compares r1 < limit until the last pass, so the body repeats
        for (int k = 1; k <= LOOP_LIMIT; k++) begin
            for (int i = 4; i < 7; i++) begin
                pc_table[1][n] = PC_BITS'(i);
                n++;
            end
        end
        pc_table[1][n]     = 8'd7;
        pc_table[1][n + 1] = 8'd8;
        fetch_count[1] = n + 2;
        for (int l = 0; l < THREADS; l++) begin
            store_table[1][l] = make_store(l, LOOP_LIMIT);
        end
        store_count[1] = THREADS;

        // Writes to r13, r14 and r15 must not stick
        program_table[2][0] = 16'h9F55;
        program_table[2][1] = 16'h9E09;
        program_table[2][2] = 16'h9D77;
        program_table[2][3] = 16'h80FF;
        program_table[2][4] = 16'h80DE;
        program_table[2][5] = 16'hF000;
        program_length[2] = 6;
        for (int i = 0; i < 6; i++) begin
            pc_table[2][i] = PC_BITS'(i);
        end
        fetch_count[2] = 6;
        for (int l = 0; l < THREADS; l++) begin
            store_table[2][l]           = make_store(l, l);
            store_table[2][THREADS + l] = make_store(0, THREADS);
        end
        store_count[2] = 2 * THREADS;
    endtask

    // Program memory answers after a random delay taken from the seeded list
    always @(posedge clk) begin
        if (program_read_valid && program_read_ready) begin
            program_read_ready <= 1'b0;
            fetch_wait <= fetch_delay[fetch_draw % DELAY_SLOTS];
            fetch_draw++;
        end else if (program_read_valid) begin
            if (fetch_wait == 0) begin
                program_read_ready <= 1'b1;
                program_read_data  <= program_mem[program_read_address];
            end else begin
                fetch_wait <= fetch_wait - 1;
            end
        end
    end

    // Data memory holds ready low for a random number of cycles per store
    always @(posedge clk) begin
        if (data_write_valid && data_write_ready) begin
            data_write_ready <= 1'b0;
            write_wait <= write_delay[write_draw % DELAY_SLOTS];
            write_draw++;
        end else if (data_write_valid) begin
            if (write_wait == 0) begin
                data_write_ready <= 1'b1;
            end else begin
                write_wait <= write_wait - 1;
            end
        end
    end

    // Fetch order and request stability
    always @(posedge clk) begin
        if (!reset) begin
            if (read_pending) begin
                if (!program_read_valid) begin
                    other_errors++;
                    $display("program_read_valid dropped before the request was accepted");
                end else begin
                    check_pc("program_read_address", program_read_address, held_address);
                end
            end
            if (program_read_valid && program_read_ready) begin
                if (fetch_index >= fetch_count[current_test]) begin
                    other_errors++;
                    $display("Test %0d fetched more words than expected", current_test);
                end else begin
                    check_pc("program_read_address", program_read_address,
                             pc_table[current_test][fetch_index]);
                end
                fetch_index++;
            end
            read_pending <= program_read_valid && !program_read_ready;
            held_address <= program_read_address;
        end
    end

    // Store order and payload stability
    always @(posedge clk) begin
        if (!reset) begin
            if (write_pending) begin
                if (!data_write_valid) begin
                    other_errors++;
                    $display("data_write_valid dropped before the store was accepted");
                end else begin
                    check_store("data_write", data_write, held_write);
                end
            end
            if (data_write_valid && data_write_ready) begin
                if (store_index >= store_count[current_test]) begin
                    other_errors++;
                    $display("Test %0d produced a store beyond the expected ones", current_test);
                end else begin
                    check_store("data_write", data_write, store_table[current_test][store_index]);
                end
                store_index++;
            end
            write_pending <= data_write_valid && !data_write_ready;
            held_write    <= data_write;
        end
    end

    task automatic run_test(input int t);
        int cycles;
        int limit;
        for (int a = 0; a < 256; a++) begin
            program_mem[a] = (a < program_length[t]) ? program_table[t][a] : {8'h00, 8'(a)};
        end
        current_test = t;
        fetch_index  = 0;
        store_index  = 0;
        limit = fetch_count[t] * (7 + MAX_FETCH_DELAY)
              + store_count[t] * (2 + MAX_WRITE_DELAY) + 20;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < limit);
        if (!done) begin
            other_errors++;
            $display("Test %0d: done did not rise within %0d cycles", t, limit);
            return;
        end
        if (fetch_index != fetch_count[t]) begin
            other_errors++;
            $display("Test %0d: %0d fetches seen, %0d expected", t, fetch_index, fetch_count[t]);
        end
        if (store_index != store_count[t]) begin
            other_errors++;
            $display("Test %0d: %0d stores seen, %0d expected", t, store_index, store_count[t]);
        end
        check_state(simt_core_inst.core_state, DONE);
        // Core must sit quietly in DONE until the next start
        repeat (5) begin
            @(negedge clk);
            check_bit("program_read_valid", program_read_valid, 1'b0);
            check_bit("done", done, 1'b1);
        end
    endtask

    initial begin
        int budget;
        reset = 1'b1;
        start = 1'b0;
        void'($urandom(32'hce9c_ecf4));
        for (int i = 0; i < DELAY_SLOTS; i++) begin
            fetch_delay[i] = $urandom_range(MAX_FETCH_DELAY, 0);
            write_delay[i] = $urandom_range(MAX_WRITE_DELAY, 0);
        end
        load_tables();
        budget = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += fetch_count[t] * (4 + MAX_FETCH_DELAY)
                    + store_count[t] * (1 + MAX_WRITE_DELAY);
        end
        watchdog_cycles = budget + WATCHDOG_MARGIN;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("program_read_valid", program_read_valid, 1'b0);
        check_bit("data_write_valid", data_write_valid, 1'b0);
        check_bit("done", done, 1'b0);
        check_state(simt_core_inst.core_state, IDLE);
        if (simt_core_inst.fetcher_state != FETCHER_IDLE) begin
            other_errors++;
            $display("Fetcher did not come out of reset idle");
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end
endmodule

//--- flist.f
src/core_pkg.sv
src/isa_pkg.sv
src/fetcher.sv
src/decoder.sv
src/alu.sv
src/reg_file.sv
src/store_unit.sv
src/core_scheduler.sv
src/simt_core.sv
tb/simt_core_tb.sv
